//--- include/bpu_macros.svh
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Fetch address width
`define PC_W 32

// Micro BTB geometry
`define UBTB_SIZE 8
`define UBTB_TAG_W 12
`define SLOT_NUM 2

// Fetch block of 8 instructions, 4 bytes each
`define BLOCK_SIZE 32
`define OFFSET_W 3

// Low target bits kept in each slot view, the rest comes from the block PC
`define COND_TGT_W 14
`define JMP_TGT_W 16

// Fetch stream queue depth
`define FSQ_DEPTH 8

`endif

//--- design/btb_pkg.sv
`include "bpu_macros.svh"

package btb_pkg;

    typedef enum logic {
        BR_COND = 1'b0,
        BR_JUMP = 1'b1
    } br_kind_e;

    // Conditional view of a slot word
    typedef struct packed {
        logic                   en;
        br_kind_e               kind;
        logic [`OFFSET_W-1:0]   offset;
        logic [1:0]             ctr;
        logic [`COND_TGT_W-1:0] target;
    } cond_slot_t;

    // Jump view, the counter bits widen the target instead
    typedef struct packed {
        logic                  en;
        br_kind_e              kind;
        logic [`OFFSET_W-1:0]  offset;
        logic [`JMP_TGT_W-1:0] target;
    } jump_slot_t;

    typedef union packed {
        cond_slot_t br;
        jump_slot_t jmp;
    } slot_u;

    typedef struct packed {
        logic                   valid;
        logic [`UBTB_TAG_W-1:0] tag;
        slot_u [`SLOT_NUM-1:0]  slots;
    } btb_entry_t;

endpackage

//--- design/stream_pkg.sv
`include "bpu_macros.svh"

package stream_pkg;

    // One predicted fetch stream, the FSQ word
    typedef struct packed {
        logic [`PC_W-1:0]     start;
        logic [`PC_W-1:0]     target;
        logic                 taken;
        logic [`OFFSET_W-1:0] offset;
    } stream_t;

    // Resolved block information sent back to the uBTB
    typedef struct packed {
        logic [`PC_W-1:0]              start;
        btb_pkg::slot_u [`SLOT_NUM-1:0] slots;
        logic [`SLOT_NUM-1:0]          taken;
        logic [`SLOT_NUM-1:0]          en;
    } ubtb_update_t;

endpackage

//--- design/ubtb.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module ubtb (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pc_valid_i,
    input  logic [`PC_W-1:0]               pc_i,
    input  logic                           upd_valid_i,
    input  logic [`PC_W-1:0]               upd_pc_i,
    input  btb_pkg::slot_u [`SLOT_NUM-1:0] upd_slot_i,
    input  logic [`SLOT_NUM-1:0]           upd_taken_i,
    input  logic [`SLOT_NUM-1:0]           upd_en_i,
    output logic                           pred_valid_o,
    output stream_pkg::stream_t            pred_stream_o
);
    import btb_pkg::*;
    import stream_pkg::*;

    localparam int BLK_OFF_W = $clog2(`BLOCK_SIZE);
    localparam int IDX_W = $clog2(`UBTB_SIZE);

    btb_entry_t             entries_q [`UBTB_SIZE];
    logic [7:0]             lfsr_q;
    logic [`UBTB_TAG_W-1:0] lookup_tag;
    logic [`UBTB_TAG_W-1:0] upd_tag;
    logic                   lookup_hit;
    logic                   upd_hit;
    logic [IDX_W-1:0]       lookup_idx;
    logic [IDX_W-1:0]       upd_idx;
    logic [IDX_W-1:0]       upd_sel;
    btb_entry_t             lookup_entry;
    btb_entry_t             upd_old;
    logic [`SLOT_NUM-1:0]   slot_taken;
    slot_u [`SLOT_NUM-1:0]  new_slots;
    stream_t                pred_d;
    stream_t                pred_q;
    logic                   pred_valid_q;

    function automatic logic [1:0] sat_ctr(input logic [1:0] ctr, input logic taken);
        logic [1:0] res;
        res = ctr;
        if (taken && ctr != 2'b11) begin
            res = ctr + 2'd1;
        end else if (!taken && ctr != 2'b00) begin
            res = ctr - 2'd1;
        end
        return res;
    endfunction

    // Upper target bits come from the block PC, width depends on the view
    function automatic logic [`PC_W-1:0] slot_target(input logic [`PC_W-1:0] pc,
                                                     input slot_u s);
        if (s.jmp.kind == BR_JUMP) begin
            return {pc[`PC_W-1:`JMP_TGT_W], s.jmp.target};
        end
        return {pc[`PC_W-1:`COND_TGT_W], s.br.target};
    endfunction

    assign lookup_tag = pc_i[BLK_OFF_W +: `UBTB_TAG_W];
    assign upd_tag    = upd_pc_i[BLK_OFF_W +: `UBTB_TAG_W];

    // Two read ports, lowest matching index wins
    always_comb begin
        lookup_hit = 1'b0;
        lookup_idx = '0;
        upd_hit    = 1'b0;
        upd_idx    = '0;
        for (int i = `UBTB_SIZE - 1; i >= 0; i--) begin
            if (entries_q[i].valid && entries_q[i].tag == lookup_tag) begin
                lookup_hit = 1'b1;
                lookup_idx = IDX_W'(i);
            end
            if (entries_q[i].valid && entries_q[i].tag == upd_tag) begin
                upd_hit = 1'b1;
                upd_idx = IDX_W'(i);
            end
        end
    end

    assign lookup_entry = entries_q[lookup_idx];
    assign upd_old      = entries_q[upd_idx];

    always_comb begin
        for (int s = 0; s < `SLOT_NUM; s++) begin
            slot_taken[s] = lookup_hit && lookup_entry.slots[s].br.en &&
                            (lookup_entry.slots[s].br.kind == BR_JUMP ||
                             lookup_entry.slots[s].br.ctr[1]);
        end
        pred_d.start  = pc_i;
        pred_d.target = pc_i + `PC_W'(`BLOCK_SIZE);
        pred_d.taken  = 1'b0;
        pred_d.offset = '0;
        // First taken branch in program order
        for (int s = 0; s < `SLOT_NUM; s++) begin
            if (slot_taken[s] &&
                (!pred_d.taken || lookup_entry.slots[s].br.offset < pred_d.offset)) begin
                pred_d.taken  = 1'b1;
                pred_d.offset = lookup_entry.slots[s].br.offset;
                pred_d.target = slot_target(pc_i, lookup_entry.slots[s]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= pc_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_valid_i) begin
            pred_q <= pred_d;
        end
    end

    assign pred_valid_o  = pred_valid_q;
    assign pred_stream_o = pred_q;

    // Counters are read live from the table, not from the update word
    always_comb begin
        for (int s = 0; s < `SLOT_NUM; s++) begin
            new_slots[s] = upd_slot_i[s];
            if (upd_en_i[s] && upd_slot_i[s].br.kind == BR_COND) begin
                if (upd_hit && upd_old.slots[s].br.en &&
                    upd_old.slots[s].br.kind == BR_COND &&
                    upd_old.slots[s].br.offset == upd_slot_i[s].br.offset) begin
                    new_slots[s].br.ctr = sat_ctr(upd_old.slots[s].br.ctr, upd_taken_i[s]);
                end else begin
                    new_slots[s].br.ctr = upd_taken_i[s] ? 2'b10 : 2'b01;
                end
            end
        end
    end

    assign upd_sel = upd_hit ? upd_idx : lfsr_q[IDX_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entries_q <= '{default: '0};
        end else if (upd_valid_i) begin
            entries_q[upd_sel] <= '{valid: 1'b1, tag: upd_tag, slots: new_slots};
        end
    end

    // Fibonacci LFSR, taps 8 6 5 4, steps once per allocation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= 8'h01;
        end else if (upd_valid_i && !upd_hit) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

endmodule

//--- design/fsq.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module fsq (
    input  logic                clk,
    input  logic                rst,
    input  logic                push_i,
    input  stream_pkg::stream_t push_stream_i,
    input  logic                pop_i,
    output stream_pkg::stream_t head_stream_o,
    output logic                full_o,
    output logic                empty_o
);
    import stream_pkg::*;

    localparam int PTR_W = $clog2(`FSQ_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`FSQ_DEPTH - 1);

    stream_t          mem_q [`FSQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = count_q == (PTR_W + 1)'(`FSQ_DEPTH);
    assign empty_o = count_q == '0;

    // A push while full only lands if the head leaves in the same cycle
    assign do_push = push_i && (!full_o || pop_i);
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_stream_i;
        end
    end

    assign head_stream_o = mem_q[rd_ptr_q];

endmodule

//--- design/bpu_commit.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module bpu_commit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           res_valid_i,
    input  stream_pkg::stream_t            head_stream_i,
    input  btb_pkg::slot_u [`SLOT_NUM-1:0] res_slot_i,
    input  logic [`SLOT_NUM-1:0]           res_taken_i,
    input  logic [`PC_W-1:0]               res_target_i,
    output logic                           pop_o,
    output logic                           commit_valid_o,
    output logic [`PC_W-1:0]               commit_pc_o,
    output logic [`PC_W-1:0]               commit_pred_target_o,
    output logic                           mispredict_o,
    output logic                           upd_valid_o,
    output logic [`PC_W-1:0]               upd_pc_o,
    output btb_pkg::slot_u [`SLOT_NUM-1:0] upd_slot_o,
    output logic [`SLOT_NUM-1:0]           upd_taken_o,
    output logic [`SLOT_NUM-1:0]           upd_en_o
);
    import stream_pkg::*;

    logic [`SLOT_NUM-1:0] res_en;
    logic                 commit_valid_q;
    logic                 upd_valid_q;
    logic [`PC_W-1:0]     commit_pc_q;
    logic [`PC_W-1:0]     pred_target_q;
    logic                 mispredict_q;
    ubtb_update_t         upd_q;

    // Head is consumed in the resolve cycle
    assign pop_o = res_valid_i;

    // A jump in the tail slot counts through its enable bit as well
    always_comb begin
        for (int s = 0; s < `SLOT_NUM; s++) begin
            res_en[s] = res_slot_i[s].br.en;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid_q <= 1'b0;
            upd_valid_q    <= 1'b0;
        end else begin
            commit_valid_q <= res_valid_i;
            upd_valid_q    <= res_valid_i && (|res_en);
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            commit_pc_q   <= head_stream_i.start;
            pred_target_q <= head_stream_i.target;
            mispredict_q  <= head_stream_i.target != res_target_i;
            upd_q         <= '{start: head_stream_i.start, slots: res_slot_i,
                               taken: res_taken_i, en: res_en};
        end
    end

    assign commit_valid_o       = commit_valid_q;
    assign commit_pc_o          = commit_pc_q;
    assign commit_pred_target_o = pred_target_q;
    assign mispredict_o         = mispredict_q;

    assign upd_valid_o = upd_valid_q;
    assign upd_pc_o    = upd_q.start;
    assign upd_slot_o  = upd_q.slots;
    assign upd_taken_o = upd_q.taken;
    assign upd_en_o    = upd_q.en;

endmodule

//--- design/bpu_top.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module bpu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pc_valid_i,
    input  logic [`PC_W-1:0]               pc_i,
    input  logic                           res_valid_i,
    input  btb_pkg::slot_u [`SLOT_NUM-1:0] res_slot_i,
    input  logic [`SLOT_NUM-1:0]           res_taken_i,
    input  logic [`PC_W-1:0]               res_target_i,
    output logic                           fsq_full_o,
    output logic                           fsq_empty_o,
    output logic                           commit_valid_o,
    output logic [`PC_W-1:0]               commit_pc_o,
    output logic [`PC_W-1:0]               commit_pred_target_o,
    output logic                           mispredict_o
);
    import btb_pkg::*;
    import stream_pkg::*;

    logic                  pred_valid;
    stream_t               pred_stream;
    stream_t               head_stream;
    logic                  pop;
    logic                  upd_valid;
    logic [`PC_W-1:0]      upd_pc;
    slot_u [`SLOT_NUM-1:0] upd_slot;
    logic [`SLOT_NUM-1:0]  upd_taken;
    logic [`SLOT_NUM-1:0]  upd_en;

    ubtb u_ubtb (
        .clk(clk), .rst(rst),
        .pc_valid_i(pc_valid_i), .pc_i(pc_i),
        .upd_valid_i(upd_valid), .upd_pc_i(upd_pc), .upd_slot_i(upd_slot),
        .upd_taken_i(upd_taken), .upd_en_i(upd_en),
        .pred_valid_o(pred_valid), .pred_stream_o(pred_stream)
    );

    fsq u_fsq (
        .clk(clk), .rst(rst),
        .push_i(pred_valid), .push_stream_i(pred_stream), .pop_i(pop),
        .head_stream_o(head_stream), .full_o(fsq_full_o), .empty_o(fsq_empty_o)
    );

    bpu_commit u_commit (
        .clk(clk), .rst(rst),
        .res_valid_i(res_valid_i), .head_stream_i(head_stream),
        .res_slot_i(res_slot_i), .res_taken_i(res_taken_i), .res_target_i(res_target_i),
        .pop_o(pop), .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_pred_target_o(commit_pred_target_o), .mispredict_o(mispredict_o),
        .upd_valid_o(upd_valid), .upd_pc_o(upd_pc), .upd_slot_o(upd_slot),
        .upd_taken_o(upd_taken), .upd_en_o(upd_en)
    );

endmodule

//--- sim/bpu_checker.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module bpu_checker (
    input logic             clk,
    input logic             rst,
    input logic             commit_valid_i,
    input logic [`PC_W-1:0] commit_pc_i,
    input logic [`PC_W-1:0] commit_pred_target_i,
    input logic             mispredict_i
);
    // Expected commit records in request order
    logic [`PC_W-1:0] exp_pc [$];
    logic [`PC_W-1:0] exp_target [$];
    logic             exp_mis [$];
    int               err_count = 0;
    int               check_count = 0;

    task automatic add_expect(input logic [`PC_W-1:0] pc, input logic [`PC_W-1:0] target,
                              input logic mis);
        exp_pc.push_back(pc);
        exp_target.push_back(target);
        exp_mis.push_back(mis);
    endtask

    function automatic int pending();
        return exp_pc.size();
    endfunction

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        logic [`PC_W-1:0] pc;
        logic [`PC_W-1:0] target;
        logic             mis;
        if (!rst && commit_valid_i) begin
            if (exp_pc.size() == 0) begin
                $display("Commit seen for pc %h while no commit was expected", commit_pc_i);
                err_count++;
            end else begin
                pc = exp_pc.pop_front();
                target = exp_target.pop_front();
                mis = exp_mis.pop_front();
                check_count++;
                if (commit_pc_i !== pc) begin
                    $display("** Error: commit_pc_o got %h expected %h", commit_pc_i, pc);
                    err_count++;
                end
                if (commit_pred_target_i !== target) begin
                    $display("** Error: commit_pred_target_o got %h expected %h (pc %h)",
                             commit_pred_target_i, target, pc);
                    err_count++;
                end
                if (mispredict_i !== mis) begin
                    $display("** Error: mispredict_o got %h expected %h (pc %h)",
                             mispredict_i, mis, pc);
                    err_count++;
                end
            end
        end
    end

endmodule

//--- sim/bpu_sva.sv
`timescale 1ns/1ps

module bpu_sva (
    input logic clk,
    input logic rst,
    input logic pc_valid_i,
    input logic res_valid_i,
    input logic fsq_full_o,
    input logic fsq_empty_o
);
    // The fetch source must hold off while the queue is full
    assert property (@(posedge clk) disable iff (rst) pc_valid_i |-> !fsq_full_o)
        else $error("pc_valid_i strobed while the queue is full");

    assert property (@(posedge clk) disable iff (rst) res_valid_i |-> !fsq_empty_o)
        else $error("res_valid_i strobed while the queue is empty");

    // A request sits in the queue two cycles after its strobe
    assert property (@(posedge clk) disable iff (rst) pc_valid_i |-> ##2 !fsq_empty_o)
        else $error("queue still empty two cycles after pc_valid_i");

endmodule

bind bpu_top bpu_sva u_sva (
    .clk(clk), .rst(rst),
    .pc_valid_i(pc_valid_i), .res_valid_i(res_valid_i),
    .fsq_full_o(fsq_full_o), .fsq_empty_o(fsq_empty_o)
);

//--- sim/tb_bpu.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tb_bpu;
    import btb_pkg::*;

    localparam int NBLK = 12;
    // Upper bound on transactions over all tests
    localparam int NTRANS = 284;
    localparam longint TIMEOUT_NS = (NTRANS * 20 + 200) * 8;

    logic                           clk = 1'b0;
    logic                           rst = 1'b1;
    logic                           pc_valid_i;
    logic [`PC_W-1:0]               pc_i;
    logic                           res_valid_i;
    slot_u [`SLOT_NUM-1:0]          res_slot_i;
    logic [`SLOT_NUM-1:0]           res_taken_i;
    logic [`PC_W-1:0]               res_target_i;
    logic                           fsq_full_o;
    logic                           fsq_empty_o;
    logic                           commit_valid_o;
    logic [`PC_W-1:0]               commit_pc_o;
    logic [`PC_W-1:0]               commit_pred_target_o;
    logic                           mispredict_o;

    logic [`PC_W-1:0]      pool_pc [NBLK];
    slot_u [`SLOT_NUM-1:0] layout [NBLK];
    logic                  m_valid [`UBTB_SIZE];
    logic [`UBTB_TAG_W-1:0] m_tag [`UBTB_SIZE];
    slot_u [`SLOT_NUM-1:0] m_slot [`UBTB_SIZE];
    logic [7:0]            m_lfsr;
    int                    pend_idx [$];
    logic [`PC_W-1:0]      pend_tgt [$];
    int                    tb_err = 0;
    int                    tests = 0;
    int                    failed = 0;

    always #4 clk = ~clk;

    bpu_top UUT (.*);

    bpu_checker u_chk (
        .clk(clk), .rst(rst), .commit_valid_i(commit_valid_o), .commit_pc_i(commit_pc_o),
        .commit_pred_target_i(commit_pred_target_o), .mispredict_i(mispredict_o)
    );

    function automatic int find_entry(input logic [`PC_W-1:0] pc);
        for (int i = 0; i < `UBTB_SIZE; i++) begin
            if (m_valid[i] && m_tag[i] == pc[5 +: `UBTB_TAG_W]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // The conditional view keeps 18 upper PC bits and the jump view 16
    function automatic logic [`PC_W-1:0] slot_addr(input logic [`PC_W-1:0] pc, input slot_u s);
        if (s.jmp.kind == BR_JUMP) begin
            return {pc[31:16], s.jmp.target};
        end
        return {pc[31:14], s.br.target};
    endfunction

    function automatic logic [`PC_W-1:0] predict(input logic [`PC_W-1:0] pc);
        int         e;
        logic       tk;
        logic [2:0] best;
        logic [`PC_W-1:0] tgt;
        e = find_entry(pc);
        tk = 1'b0;
        best = '0;
        tgt = pc + 32;
        if (e >= 0) begin
            for (int s = 0; s < `SLOT_NUM; s++) begin
                if (m_slot[e][s].br.en && (m_slot[e][s].br.kind == BR_JUMP ||
                    m_slot[e][s].br.ctr[1]) && (!tk || m_slot[e][s].br.offset < best)) begin
                    tk = 1'b1;
                    best = m_slot[e][s].br.offset;
                    tgt = slot_addr(pc, m_slot[e][s]);
                end
            end
        end
        return tgt;
    endfunction

    task automatic model_update(input logic [`PC_W-1:0] pc, input slot_u [`SLOT_NUM-1:0] w,
                                input logic [`SLOT_NUM-1:0] tk);
        int    hit;
        int    idx;
        slot_u [`SLOT_NUM-1:0] nw;
        logic [1:0] c;
        hit = find_entry(pc);
        nw = w;
        for (int s = 0; s < `SLOT_NUM; s++) begin
            if (w[s].br.en && w[s].br.kind == BR_COND) begin
                if (hit >= 0 && m_slot[hit][s].br.en && m_slot[hit][s].br.kind == BR_COND &&
                    m_slot[hit][s].br.offset == w[s].br.offset) begin
                    c = m_slot[hit][s].br.ctr;
                    if (tk[s] && c != 2'b11) c = c + 2'd1;
                    else if (!tk[s] && c != 2'b00) c = c - 2'd1;
                    nw[s].br.ctr = c;
                end else begin
                    nw[s].br.ctr = tk[s] ? 2'b10 : 2'b01;
                end
            end
        end
        if (hit < 0) begin
            idx = int'(m_lfsr[2:0]);
            m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5] ^ m_lfsr[4] ^ m_lfsr[3]};
        end else begin
            idx = hit;
        end
        m_valid[idx] = 1'b1;
        m_tag[idx] = pc[5 +: `UBTB_TAG_W];
        m_slot[idx] = nw;
    endtask

    task automatic push_block(input int b);
        @(posedge clk);
        pc_valid_i <= 1'b1;
        pc_i <= pool_pc[b];
        pend_idx.push_back(b);
        pend_tgt.push_back(predict(pool_pc[b]));
    endtask

    task automatic resolve_head();
        int    b;
        logic [`PC_W-1:0] pc;
        logic [`PC_W-1:0] pt;
        logic [`PC_W-1:0] actual;
        slot_u [`SLOT_NUM-1:0] w;
        logic [`SLOT_NUM-1:0] tk;
        b = pend_idx.pop_front();
        pt = pend_tgt.pop_front();
        pc = pool_pc[b];
        w = layout[b];
        for (int s = 0; s < `SLOT_NUM; s++) begin
            tk[s] = w[s].br.en && (w[s].br.kind == BR_JUMP || $urandom_range(1, 0) == 1);
        end
        // Slot 0 always sits at the lower offset
        actual = pc + 32;
        if (tk[0]) actual = slot_addr(pc, w[0]);
        else if (tk[1]) actual = slot_addr(pc, w[1]);
        u_chk.add_expect(pc, pt, pt != actual);
        if (|{w[0].br.en, w[1].br.en}) model_update(pc, w, tk);
        @(posedge clk);
        res_valid_i <= 1'b1;
        res_slot_i <= w;
        res_taken_i <= tk;
        res_target_i <= actual;
    endtask

    // Mode 0 draws from the first six blocks and mode 1 from their jump blocks
    task automatic run_batch(input int mode, input int n);
        for (int i = 0; i < n; i++) begin
            case (mode)
                0: push_block($urandom_range(5, 0));
                1: push_block(2 * $urandom_range(2, 0));
                default: push_block($urandom_range(NBLK - 1, 0));
            endcase
        end
        @(posedge clk);
        pc_valid_i <= 1'b0;
        if (n == `FSQ_DEPTH) begin
            // The last request lands in the queue two edges after its strobe
            @(posedge clk);
            @(negedge clk);
            if (fsq_full_o !== 1'b1) begin
                $display("Queue did not report full after %0d open requests", n);
                tb_err++;
            end
        end
        for (int i = 0; i < n; i++) begin
            resolve_head();
        end
        @(posedge clk);
        res_valid_i <= 1'b0;
        while (u_chk.pending() != 0) @(posedge clk);
        @(negedge clk);
        if (fsq_empty_o !== 1'b1) begin
            $display("Queue did not report empty after all requests resolved");
            tb_err++;
        end
    endtask

    task automatic finish_test(input string name, input int err_base);
        int errs;
        errs = u_chk.err_count + tb_err - err_base;
        tests++;
        if (errs != 0) failed++;
        $display("test %-12s %s, %0d errors", name, errs == 0 ? "ok" : "FAILED", errs);
    endtask

    initial begin
        int base;
        void'($urandom(32'h3ee3afa9));
        pc_valid_i <= 1'b0;
        pc_i <= '0;
        res_valid_i <= 1'b0;
        res_slot_i <= '0;
        res_taken_i <= '0;
        res_target_i <= '0;
        m_lfsr = 8'h01;
        for (int i = 0; i < `UBTB_SIZE; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_slot[i] = '0;
        end
        // Each block gets its own tag and random upper bits
        // Even blocks end in a jump
        for (int b = 0; b < NBLK; b++) begin
            pool_pc[b] = {15'($urandom_range(32'h7fff, 0)), 17'h0} | ((b + 1) << 5);
            layout[b] = '0;
            layout[b][0].br.en = 1'($urandom_range(1, 0));
            layout[b][0].br.kind = BR_COND;
            layout[b][0].br.offset = 3'($urandom_range(6, 0));
            layout[b][0].br.target = 14'($urandom_range(16383, 0)) & 14'h3ffc;
            if (b % 2 == 0) begin
                layout[b][1].jmp.en = 1'b1;
                layout[b][1].jmp.kind = BR_JUMP;
                layout[b][1].jmp.offset = layout[b][0].br.offset + 3'd1;
                layout[b][1].jmp.target = 16'($urandom_range(65535, 0)) & 16'hfffc;
            end else begin
                layout[b][1].br.en = 1'b1;
                layout[b][1].br.kind = BR_COND;
                layout[b][1].br.offset = layout[b][0].br.offset + 3'd1;
                layout[b][1].br.target = 14'($urandom_range(16383, 0)) & 14'h3ffc;
            end
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        base = u_chk.err_count + tb_err;
        for (int b = 0; b < 6; b++) push_block(b);
        @(posedge clk);
        pc_valid_i <= 1'b0;
        for (int b = 0; b < 6; b++) resolve_head();
        @(posedge clk);
        res_valid_i <= 1'b0;
        while (u_chk.pending() != 0) @(posedge clk);
        @(posedge clk);
        finish_test("cold_start", base);
        base = u_chk.err_count + tb_err;
        for (int i = 0; i < 20; i++) run_batch(0, $urandom_range(4, 1));
        finish_test("training", base);
        base = u_chk.err_count + tb_err;
        for (int i = 0; i < 10; i++) run_batch(1, 3);
        finish_test("jump_slot", base);
        base = u_chk.err_count + tb_err;
        for (int i = 0; i < 20; i++) run_batch(2, $urandom_range(8, 1));
        finish_test("replacement", base);
        base = u_chk.err_count + tb_err;
        run_batch(2, `FSQ_DEPTH);
        finish_test("full_queue", base);
        $display("%0d tests, %0d failed, %0d commits checked, %0d errors", tests, failed,
                 u_chk.check_count, u_chk.err_count + tb_err);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

//--- bpu.f
+incdir+include
design/btb_pkg.sv
design/stream_pkg.sv
design/ubtb.sv
design/fsq.sv
design/bpu_commit.sv
design/bpu_top.sv
sim/bpu_checker.sv
sim/bpu_sva.sv
sim/tb_bpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_bpu -f bpu.f -Mdir obj_dir

./obj_dir/Vtb_bpu | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
